//--- common/mdom_bus_pkg.sv
/*
 * Types of the register bus between the parallel bus front end and the
 * register map. Modules import it inside their body.
 */
`include "mdom_defines.svh"

package mdom_bus_pkg;

  // bus address and data word
  typedef logic [`MDOM_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [`MDOM_DATA_BITS-1:0] reg_data_t;

  // write request, strobe high for one lclk per bus write
  typedef struct packed {
    logic      strobe;
    reg_addr_t addr;
    reg_data_t data;
  } reg_wr_t;

  // read request
  // en is high for as long as the master reads
  typedef struct packed {
    logic      en;
    reg_addr_t addr;
  } reg_rd_t;

endpackage

//--- common/mdom_defines.svh
/*
 * Shared widths, channel count, firmware version and register addresses
 * for the mDOM slow-control path. Include wherever one of these is needed.
 */
`ifndef MDOM_DEFINES_SVH
`define MDOM_DEFINES_SVH

// channel count and discriminator samples per lclk
`define MDOM_N_CHANNELS 4
`define MDOM_DISCR_BITS 8

// parallel bus widths
`define MDOM_ADDR_BITS 12
`define MDOM_DATA_BITS 16

// returned by the version register
`define MDOM_FW_VNUM 16'h000e

// register addresses
`define MDOM_ADR_VNUM             12'hfff
`define MDOM_ADR_SCALER_RST       12'hbe9
`define MDOM_ADR_SCALER_PERIOD_HI 12'hbba
`define MDOM_ADR_SCALER_PERIOD_LO 12'hbb9
// channel select, taken modulo the channel count
`define MDOM_ADR_SCALER_SEL       12'hbb8
`define MDOM_ADR_SCALER_RB_HI     12'hbb7
`define MDOM_ADR_SCALER_RB_LO     12'hbb6

`endif

//--- common/mdom_scaler_pkg.sv
/*
 * Types for the discriminator rate scalers: window configuration, the
 * per-lclk sample word and the count word as seen by the register map.
 */
`include "mdom_defines.svh"

package mdom_scaler_pkg;

  // window length in lclk cycles, 0 holds all scalers idle
  typedef struct packed {
    logic [31:0] period;
  } scaler_cfg_t;

  // one lclk of samples
  // bit 0 is the earliest
  typedef logic [`MDOM_DISCR_BITS-1:0] discr_word_t;

  // count word, or the same word as two bus halves for readback
  typedef union packed {
    logic [31:0] count;
    struct packed {
      mdom_bus_pkg::reg_data_t hi;
      mdom_bus_pkg::reg_data_t lo;
    } half;
  } scaler_count_u;

endpackage

//--- hw/fmc/fmc_bus_frontend.sv
/*
 * Front end of the FMC-style parallel bus from the microcontroller.
 * Synchronizes the write strobe, detects its falling edge and turns each
 * bus write into a one-cycle write request; reads pass through live.
 */
`timescale 1ns/1ps

module fmc_bus_frontend (
  input  logic                    lclk,
  input  logic                    lclk_rst,
  input  mdom_bus_pkg::reg_addr_t i_fmc_a,
  input  mdom_bus_pkg::reg_data_t i_fmc_din,
  input  logic                    i_fmc_cen_n,
  input  logic                    i_fmc_oen_n,
  input  logic                    i_fmc_wen_n,
  output mdom_bus_pkg::reg_wr_t   o_wr,
  output mdom_bus_pkg::reg_rd_t   o_rd
);
  import mdom_bus_pkg::*;

  // two-stage synchronizer on wen
  logic      wen_s1;
  logic      wen_s2;
  // edge detector with its delayed copy and registered pulse
  logic      wen_s2_d;
  logic      wen_fall;
  // write-side copies of the bus
  logic      cen_q;
  reg_addr_t addr_q;
  reg_data_t data_q;

  // idle level of wen is high, so no edge is seen out of reset
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      wen_s1   <= 1'b1;
      wen_s2   <= 1'b1;
      wen_s2_d <= 1'b1;
      wen_fall <= 1'b0;
    end else begin
      wen_s1   <= i_fmc_wen_n;
      wen_s2   <= wen_s1;
      wen_s2_d <= wen_s2;
      // high for one cycle after the 3rd edge
      wen_fall <= wen_s2_d & ~wen_s2;
    end
  end

  // chip enable registered alongside address and data
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      cen_q <= 1'b1;
    end else begin
      cen_q <= i_fmc_cen_n;
    end
  end

  always_ff @(posedge lclk) begin
    addr_q <= i_fmc_a;
    data_q <= i_fmc_din;
  end

  // one write per wen fall as burst writes are not supported
  assign o_wr.strobe = wen_fall & ~cen_q;
  assign o_wr.addr   = addr_q;
  assign o_wr.data   = data_q;

  // reads use the live address
  assign o_rd.en   = ~i_fmc_oen_n & ~i_fmc_cen_n;
  assign o_rd.addr = i_fmc_a;

endmodule

//--- hw/mdom_slow_ctrl_top.sv
/*
 * Top level of the mDOM slow-control path. The bus front end feeds the
 * register map, which configures one rate scaler per channel and reads
 * their counts back. Pad and tristate control stay outside.
 */
`timescale 1ns/1ps
`include "mdom_defines.svh"

module mdom_slow_ctrl_top (
  input  logic                         lclk,
  input  logic                         lclk_rst,
  input  mdom_bus_pkg::reg_addr_t      i_fmc_a,
  input  mdom_bus_pkg::reg_data_t      i_fmc_din,
  input  logic                         i_fmc_cen_n,
  input  logic                         i_fmc_oen_n,
  input  logic                         i_fmc_wen_n,
  input  mdom_scaler_pkg::discr_word_t i_discr [`MDOM_N_CHANNELS],
  output mdom_bus_pkg::reg_data_t      o_fmc_dout
);
  import mdom_bus_pkg::*;
  import mdom_scaler_pkg::*;

  // front end to register map
  reg_wr_t                     bus_wr;
  reg_rd_t                     bus_rd;
  // register map to scalers
  scaler_cfg_t                 scaler_cfg;
  logic [`MDOM_N_CHANNELS-1:0] scaler_rst;
  // scaler counts back to the register map
  logic [31:0]                 counts [`MDOM_N_CHANNELS];

  fmc_bus_frontend frontend_i (
    .lclk        (lclk),
    .lclk_rst    (lclk_rst),
    .i_fmc_a     (i_fmc_a),
    .i_fmc_din   (i_fmc_din),
    .i_fmc_cen_n (i_fmc_cen_n),
    .i_fmc_oen_n (i_fmc_oen_n),
    .i_fmc_wen_n (i_fmc_wen_n),
    .o_wr        (bus_wr),
    .o_rd        (bus_rd)
  );

  slow_ctrl_regs regs_i (
    .lclk         (lclk),
    .lclk_rst     (lclk_rst),
    .i_wr         (bus_wr),
    .i_rd         (bus_rd),
    .i_counts     (counts),
    .o_fmc_dout   (o_fmc_dout),
    .o_scaler_cfg (scaler_cfg),
    .o_scaler_rst (scaler_rst)
  );

  // one scaler per channel, sharing the window configuration
  for (genvar ch = 0; ch < `MDOM_N_CHANNELS; ch++) begin : g_scaler
    discr_scaler scaler_i (
      .lclk       (lclk),
      .lclk_rst   (lclk_rst),
      .i_rst_chan (scaler_rst[ch]),
      .i_cfg      (scaler_cfg),
      .i_discr    (i_discr[ch]),
      .o_count    (counts[ch])
    );
  end

endmodule

//--- hw/regs/slow_ctrl_regs.sv
/*
 * Slow-control register map. Decodes write requests into the scaler
 * period, reset mask and readback select, and drives the registered
 * readback word. A low-half scaler read snapshots the full count.
 */
`timescale 1ns/1ps
`include "mdom_defines.svh"

module slow_ctrl_regs (
  input  logic                          lclk,
  input  logic                          lclk_rst,
  input  mdom_bus_pkg::reg_wr_t         i_wr,
  input  mdom_bus_pkg::reg_rd_t         i_rd,
  input  logic [31:0]                   i_counts [`MDOM_N_CHANNELS],
  output mdom_bus_pkg::reg_data_t       o_fmc_dout,
  output mdom_scaler_pkg::scaler_cfg_t  o_scaler_cfg,
  output logic [`MDOM_N_CHANNELS-1:0]   o_scaler_rst
);
  import mdom_bus_pkg::*;
  import mdom_scaler_pkg::*;

  // stored width of the select register
  localparam int SEL_BITS = 5;
  // width of a channel index
  localparam int CH_BITS = (`MDOM_N_CHANNELS > 1) ? $clog2(`MDOM_N_CHANNELS) : 1;

  logic [31:0]                 period_q;
  logic [`MDOM_N_CHANNELS-1:0] rst_mask_q;
  logic [SEL_BITS-1:0]         sel_q;
  logic [CH_BITS-1:0]          chan;
  // live count of the selected channel
  scaler_count_u               sel_count;
  // count captured on the low-half read
  scaler_count_u               snap_q;
  reg_data_t                   rb_data;

  // write decode
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      period_q   <= '0;
      rst_mask_q <= '0;
      sel_q      <= '0;
    end else if (i_wr.strobe) begin
      case (i_wr.addr)
        `MDOM_ADR_SCALER_PERIOD_HI: begin
          period_q[31:16] <= i_wr.data;
        end
        `MDOM_ADR_SCALER_PERIOD_LO: begin
          period_q[15:0] <= i_wr.data;
        end
        // only the channel bits are kept
        `MDOM_ADR_SCALER_RST: begin
          rst_mask_q <= i_wr.data[`MDOM_N_CHANNELS-1:0];
        end
        `MDOM_ADR_SCALER_SEL: begin
          sel_q <= i_wr.data[SEL_BITS-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  assign o_scaler_cfg.period = period_q;
  assign o_scaler_rst        = rst_mask_q;

  // select wraps around the channel count
  assign chan            = CH_BITS'(sel_q % `MDOM_N_CHANNELS);
  assign sel_count.count = i_counts[chan];

  // readback mux on the request address
  always_comb begin
    rb_data = '0;
    case (i_rd.addr)
      `MDOM_ADR_VNUM: begin
        rb_data = `MDOM_FW_VNUM;
      end
      `MDOM_ADR_SCALER_PERIOD_HI: begin
        rb_data = period_q[31:16];
      end
      `MDOM_ADR_SCALER_PERIOD_LO: begin
        rb_data = period_q[15:0];
      end
      `MDOM_ADR_SCALER_SEL: begin
        rb_data = reg_data_t'(sel_q);
      end
      `MDOM_ADR_SCALER_RST: begin
        rb_data = reg_data_t'(rst_mask_q);
      end
      // high half always comes from the snapshot
      `MDOM_ADR_SCALER_RB_HI: begin
        rb_data = snap_q.half.hi;
      end
      // low half straight from the count being captured
      `MDOM_ADR_SCALER_RB_LO: begin
        rb_data = sel_count.half.lo;
      end
      // unmapped reads return zero
      default: begin
        rb_data = '0;
      end
    endcase
  end

  // registered readback and snapshot
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      o_fmc_dout <= '0;
      snap_q     <= '0;
    end else begin
      // zero whenever no read is in progress
      o_fmc_dout <= i_rd.en ? rb_data : '0;
      if (i_rd.en && (i_rd.addr == `MDOM_ADR_SCALER_RB_LO)) begin
        snap_q <= sel_count;
      end
    end
  end

endmodule

//--- hw/scaler/discr_scaler.sv
/*
 * Rate scaler for one discriminator channel. Counts rising edges in the
 * 8-sample word of each lclk, including the edge across word boundaries,
 * and publishes the total once per programmable window.
 */
`timescale 1ns/1ps
`include "mdom_defines.svh"

module discr_scaler (
  input  logic                         lclk,
  input  logic                         lclk_rst,
  input  logic                         i_rst_chan,
  input  mdom_scaler_pkg::scaler_cfg_t i_cfg,
  input  mdom_scaler_pkg::discr_word_t i_discr,
  output logic [31:0]                  o_count
);
  import mdom_scaler_pkg::*;

  // enough bits to hold one word's edge count
  localparam int EDGE_BITS = $clog2(`MDOM_DISCR_BITS + 1);

  // last sample of the previous word
  logic                 prev_bit;
  discr_word_t          rise;
  logic [EDGE_BITS-1:0] n_edges;
  logic                 hold;
  logic [31:0]          win_cnt;
  logic [31:0]          acc;

  // sample i is compared against sample i-1, bit 0 against prev_bit
  assign rise = i_discr & ~{i_discr[`MDOM_DISCR_BITS-2:0], prev_bit};

  // popcount of rising edges
  always_comb begin
    n_edges = '0;
    for (int b = 0; b < `MDOM_DISCR_BITS; b++) begin
      n_edges = n_edges + EDGE_BITS'(rise[b]);
    end
  end

  // keeps tracking the input even while the channel is held
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      prev_bit <= 1'b0;
    end else begin
      prev_bit <= i_discr[`MDOM_DISCR_BITS-1];
    end
  end

  // idle while masked or with no window set
  assign hold = i_rst_chan || (i_cfg.period == '0);

  // window counter and accumulator
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      win_cnt <= '0;
      acc     <= '0;
      o_count <= '0;
    end else if (hold) begin
      // published count survives a channel reset
      win_cnt <= '0;
      acc     <= '0;
    end else if (win_cnt == i_cfg.period - 32'd1) begin
      // last cycle of the window includes its own edges
      o_count <= acc + 32'(n_edges);
      acc     <= '0;
      win_cnt <= '0;
    end else begin
      acc     <= acc + 32'(n_edges);
      win_cnt <= win_cnt + 32'd1;
    end
  end

endmodule

//--- mdom_slow_ctrl_top.f
+incdir+common
common/mdom_bus_pkg.sv
common/mdom_scaler_pkg.sv
hw/fmc/fmc_bus_frontend.sv
hw/regs/slow_ctrl_regs.sv
hw/scaler/discr_scaler.sv
hw/mdom_slow_ctrl_top.sv
verification/mdom_slow_ctrl_assertions.sv
verification/mdom_slow_ctrl_tb.sv

//--- verification/mdom_slow_ctrl_assertions.sv
/*
 * Concurrent checks on the register map, attached by bind. The bound copy
 * watches the write strobe arriving from the front end, the readback word
 * and the scaler reset mask.
 */
`timescale 1ns/1ps
`include "mdom_defines.svh"

module mdom_slow_ctrl_assertions (
  input logic                         lclk,
  input logic                         lclk_rst,
  input logic                         i_wr_strobe,
  input logic                         i_rd_en,
  input logic [`MDOM_DATA_BITS-1:0]   i_dout,
  input logic [`MDOM_N_CHANNELS-1:0]  i_rst_mask
);

  // one bus write gives exactly one strobe cycle
  strobe_single_cycle: assert property (@(posedge lclk) disable iff (lclk_rst)
    i_wr_strobe |=> !i_wr_strobe)
    else $error("write strobe held for two cycles");

  // readback idles at zero when no read is in progress
  dout_idle_zero: assert property (@(posedge lclk) disable iff (lclk_rst)
    !i_rd_en |=> (i_dout == '0))
    else $error("readback word not zero outside a read");

  // synchronous reset clears the mask
  mask_cleared: assert property (@(posedge lclk)
    lclk_rst |=> (i_rst_mask == '0))
    else $error("scaler reset mask not zero after reset");

endmodule

bind slow_ctrl_regs mdom_slow_ctrl_assertions regs_assert_i (
  .lclk        (lclk),
  .lclk_rst    (lclk_rst),
  .i_wr_strobe (i_wr.strobe),
  .i_rd_en     (i_rd.en),
  .i_dout      (o_fmc_dout),
  .i_rst_mask  (o_scaler_rst)
);

//--- verification/mdom_slow_ctrl_tb.sv
/*
 * Testbench for the slow-control top level. Drives the parallel bus and
 * LFSR discriminator words on the falling edge, keeps a cycle model of the
 * registers and scalers, and compares every bus read against it.
 */
`timescale 1ns/1ps
`include "mdom_defines.svh"

module mdom_slow_ctrl_tb;
  import mdom_bus_pkg::*;
  import mdom_scaler_pkg::*;

  localparam int NCH = `MDOM_N_CHANNELS;
  localparam int RST_CYCLES = 5;
  // one write is 8 cycles, one read 2
  localparam int WRITE_CYCLES = 8;
  localparam int READ_CYCLES = 2;
  // window long enough for the count to reach its high half
  localparam int BIG_PERIOD = 49152;
  localparam int TIMEOUT_CYCLES = RST_CYCLES + 90 * WRITE_CYCLES + 130 * READ_CYCLES
                                  + 1400 + BIG_PERIOD + 500;
  // select register keeps 5 bits
  localparam logic [15:0] SEL_MASK = 16'h001f;
  // reset bit of every channel
  localparam logic [15:0] ALL_CH_MASK = (1 << NCH) - 1;

  logic        lclk;
  logic        lclk_rst;
  reg_addr_t   fmc_a;
  reg_data_t   fmc_din;
  logic        fmc_cen_n;
  logic        fmc_oen_n;
  logic        fmc_wen_n;
  discr_word_t discr [NCH];
  reg_data_t   fmc_dout;

  logic [31:0] main_lfsr;
  logic [31:0] disc_lfsr;
  // 0 random words, 1 fixed boundary patterns
  logic        pattern_mode;
  logic        phase;
  int          cycles;

  // model state
  logic [31:0] period_m;
  logic [NCH-1:0] mask_m;
  logic [15:0] sel_m;
  logic [31:0] win_m [NCH];
  logic [31:0] acc_m [NCH];
  logic [31:0] pub_m [NCH];
  logic        prev_m [NCH];
  logic [31:0] snap_m;
  // write waiting for its 4th edge
  int          wr_pend;
  reg_addr_t   wr_pend_addr;
  reg_data_t   wr_pend_data;

  mdom_slow_ctrl_top dut_i (
    .lclk        (lclk),
    .lclk_rst    (lclk_rst),
    .i_fmc_a     (fmc_a),
    .i_fmc_din   (fmc_din),
    .i_fmc_cen_n (fmc_cen_n),
    .i_fmc_oen_n (fmc_oen_n),
    .i_fmc_wen_n (fmc_wen_n),
    .i_discr     (discr),
    .o_fmc_dout  (fmc_dout)
  );

  initial begin
    lclk = 1'b0;
    forever #4 lclk = ~lclk;
  end

  // galois lfsr with taps x^32+x^30+x^26+x^25+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  // one step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = main_lfsr[0];
      main_lfsr = lfsr_step(main_lfsr);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // discriminator words
  always @(negedge lclk) begin
    phase <= ~phase;
    for (int ch = 0; ch < NCH; ch++) begin
      if (pattern_mode) begin
        case (ch)
          0: discr[ch] <= 8'h01;
          1: discr[ch] <= 8'h81;
          2: discr[ch] <= phase ? 8'h80 : 8'h00;
          default: discr[ch] <= phase ? 8'h80 : 8'h01;
        endcase
      end else begin
        for (int b = 0; b < 8; b++) begin
          discr[ch][b] <= disc_lfsr[0];
          disc_lfsr = lfsr_step(disc_lfsr);
        end
      end
    end
  end

  // cycle model where the scalers step on the old config before a write lands
  always @(posedge lclk) begin
    logic [7:0] w;
    logic       p;
    int         e;
    cycles <= cycles + 1;
    if (lclk_rst) begin
      period_m <= '0;
      mask_m   <= '0;
      sel_m    <= '0;
      snap_m   <= '0;
      for (int ch = 0; ch < NCH; ch++) begin
        win_m[ch]  <= '0;
        acc_m[ch]  <= '0;
        pub_m[ch]  <= '0;
        prev_m[ch] <= 1'b0;
      end
    end else begin
      for (int ch = 0; ch < NCH; ch++) begin
        w = discr[ch];
        p = prev_m[ch];
        e = 0;
        // rising sample, previous one low
        for (int b = 0; b < 8; b++) begin
          if (w[b] && !p) begin
            e++;
          end
          p = w[b];
        end
        prev_m[ch] <= w[7];
        if (mask_m[ch] || period_m == 0) begin
          win_m[ch] <= '0;
          acc_m[ch] <= '0;
        end else if (win_m[ch] == period_m - 1) begin
          pub_m[ch] <= acc_m[ch] + e;
          acc_m[ch] <= '0;
          win_m[ch] <= '0;
        end else begin
          acc_m[ch] <= acc_m[ch] + e;
          win_m[ch] <= win_m[ch] + 1;
        end
      end
      if (wr_pend == 1) begin
        case (wr_pend_addr)
          `MDOM_ADR_SCALER_PERIOD_HI: period_m[31:16] <= wr_pend_data;
          `MDOM_ADR_SCALER_PERIOD_LO: period_m[15:0] <= wr_pend_data;
          `MDOM_ADR_SCALER_RST: mask_m <= wr_pend_data[NCH-1:0];
          `MDOM_ADR_SCALER_SEL: sel_m <= wr_pend_data & SEL_MASK;
          default: begin
          end
        endcase
      end
      if (wr_pend > 0) begin
        wr_pend <= wr_pend - 1;
      end
    end
  end

  always @(posedge lclk) begin
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1);
    end
  end

  task automatic idle(input int n);
    repeat (n) @(negedge lclk);
  endtask

  // wen low for 5 cycles, register holds the value from the 4th edge on
  task automatic bus_write(input reg_addr_t a, input reg_data_t d);
    @(negedge lclk);
    fmc_a     = a;
    fmc_din   = d;
    fmc_cen_n = 1'b0;
    fmc_wen_n = 1'b0;
    wr_pend      = 4;
    wr_pend_addr = a;
    wr_pend_data = d;
    idle(5);
    fmc_wen_n = 1'b1;
    fmc_cen_n = 1'b1;
    idle(2);
  endtask

  // expected readback for the model state before the next edge
  function automatic reg_data_t expected_rb(input reg_addr_t a);
    case (a)
      `MDOM_ADR_VNUM: expected_rb = `MDOM_FW_VNUM;
      `MDOM_ADR_SCALER_PERIOD_HI: expected_rb = period_m[31:16];
      `MDOM_ADR_SCALER_PERIOD_LO: expected_rb = period_m[15:0];
      `MDOM_ADR_SCALER_SEL: expected_rb = sel_m;
      `MDOM_ADR_SCALER_RST: expected_rb = reg_data_t'(mask_m);
      `MDOM_ADR_SCALER_RB_HI: expected_rb = snap_m[31:16];
      `MDOM_ADR_SCALER_RB_LO: expected_rb = pub_m[sel_m % NCH][15:0];
      default: expected_rb = '0;
    endcase
  endfunction

  // single-edge read checked at the next falling edge
  task automatic check_read(input reg_addr_t a, input string name,
                            output reg_data_t got);
    reg_data_t exp;
    @(negedge lclk);
    fmc_a     = a;
    fmc_cen_n = 1'b0;
    fmc_oen_n = 1'b0;
    exp = expected_rb(a);
    if (a == `MDOM_ADR_SCALER_RB_LO) begin
      snap_m = pub_m[sel_m % NCH];
    end
    @(negedge lclk);
    got = fmc_dout;
    fmc_oen_n = 1'b1;
    fmc_cen_n = 1'b1;
    check_value(name, got, exp);
  endtask

  task automatic read_count(input int ch, output logic [31:0] cnt);
    reg_data_t lo;
    reg_data_t hi;
    bus_write(`MDOM_ADR_SCALER_SEL, reg_data_t'(ch));
    check_read(`MDOM_ADR_SCALER_RB_LO, "scaler_rb_lo", lo);
    check_read(`MDOM_ADR_SCALER_RB_HI, "scaler_rb_hi", hi);
    cnt = {hi, lo};
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] per;
    logic [31:0] c0;
    logic [31:0] c1;
    reg_data_t   d;
    int          k;
    main_lfsr    = 32'hd9ce_30c7;
    disc_lfsr    = 32'hd9ce_30c7;
    pattern_mode = 1'b0;
    phase        = 1'b0;
    cycles       = 0;
    wr_pend      = 0;
    wr_pend_addr = '0;
    wr_pend_data = '0;
    fmc_a     = '0;
    fmc_din   = '0;
    fmc_cen_n = 1'b1;
    fmc_oen_n = 1'b1;
    fmc_wen_n = 1'b1;
    for (int ch = 0; ch < NCH; ch++) begin
      discr[ch] = '0;
    end
    lclk_rst = 1'b1;
    repeat (RST_CYCLES) @(negedge lclk);
    lclk_rst = 1'b0;

    // reset values and the version word
    check_read(`MDOM_ADR_VNUM, "vnum", d);
    check_read(`MDOM_ADR_SCALER_PERIOD_HI, "period_hi", d);
    check_read(`MDOM_ADR_SCALER_PERIOD_LO, "period_lo", d);
    check_read(`MDOM_ADR_SCALER_RST, "scaler_rst", d);
    check_read(`MDOM_ADR_SCALER_SEL, "scaler_sel", d);
    check_read(`MDOM_ADR_SCALER_RB_LO, "scaler_rb_lo", d);
    check_read(`MDOM_ADR_SCALER_RB_HI, "scaler_rb_hi", d);
    check_read(12'h123, "unmapped", d);

    // random register values read back
    for (int i = 0; i < 8; i++) begin
      take_bits(16, r);
      bus_write(`MDOM_ADR_SCALER_PERIOD_HI, r[15:0]);
      take_bits(16, r);
      bus_write(`MDOM_ADR_SCALER_PERIOD_LO, r[15:0]);
      take_bits(16, r);
      bus_write(`MDOM_ADR_SCALER_RST, r[15:0]);
      take_bits(16, r);
      bus_write(`MDOM_ADR_SCALER_SEL, r[15:0]);
      check_read(`MDOM_ADR_SCALER_PERIOD_HI, "period_hi", d);
      check_read(`MDOM_ADR_SCALER_PERIOD_LO, "period_lo", d);
      check_read(`MDOM_ADR_SCALER_RST, "scaler_rst", d);
      check_read(`MDOM_ADR_SCALER_SEL, "scaler_sel", d);
    end
    // every channel held while the window changes
    bus_write(`MDOM_ADR_SCALER_RST, ALL_CH_MASK);

    // random window, random words, counts at random times
    take_bits(6, r);
    per = 4 + (r % 37);
    bus_write(`MDOM_ADR_SCALER_PERIOD_HI, 16'h0000);
    bus_write(`MDOM_ADR_SCALER_PERIOD_LO, per[15:0]);
    bus_write(`MDOM_ADR_SCALER_RST, 16'h0000);
    idle(2 * per);
    for (int i = 0; i < 12; i++) begin
      take_bits(6, r);
      idle(r);
      take_bits(2, r);
      read_count(r, c0);
    end

    // word boundary patterns where period 8 gives exact expected counts
    pattern_mode = 1'b1;
    bus_write(`MDOM_ADR_SCALER_RST, ALL_CH_MASK);
    bus_write(`MDOM_ADR_SCALER_PERIOD_LO, 16'd8);
    bus_write(`MDOM_ADR_SCALER_RST, 16'h0000);
    idle(24);
    for (int ch = 0; ch < NCH; ch++) begin
      read_count(ch, c0);
      check_value("boundary_count", c0, (ch < 2) ? 32'd8 : 32'd4);
    end
    pattern_mode = 1'b0;

    // hold one channel, the others keep counting
    take_bits(2, r);
    k = r;
    bus_write(`MDOM_ADR_SCALER_RST, reg_data_t'(1 << k));
    idle(3 * per);
    read_count(k, c0);
    idle(2 * per);
    read_count(k, c1);
    check_value("held_count", c1, c0);
    for (int ch = 0; ch < NCH; ch++) begin
      read_count(ch, c0);
    end
    bus_write(`MDOM_ADR_SCALER_RST, 16'h0000);
    idle(per + 3);
    for (int ch = 0; ch < NCH; ch++) begin
      read_count(ch, c0);
    end

    // high half stays on the snapshot taken by the low read
    bus_write(`MDOM_ADR_SCALER_SEL, 16'h0000);
    // long window so the count reaches its high half
    bus_write(`MDOM_ADR_SCALER_PERIOD_LO, reg_data_t'(BIG_PERIOD));
    idle(BIG_PERIOD + 8);
    check_read(`MDOM_ADR_SCALER_RB_LO, "scaler_rb_lo", d);
    // short window publishes a count with a zero high half
    bus_write(`MDOM_ADR_SCALER_RST, ALL_CH_MASK);
    bus_write(`MDOM_ADR_SCALER_PERIOD_LO, 16'd8);
    bus_write(`MDOM_ADR_SCALER_RST, 16'h0000);
    idle(24);
    check_read(`MDOM_ADR_SCALER_RB_HI, "scaler_rb_hi", d);

    $display("Test passed");
    $finish;
  end

endmodule
